// ==== source/apu_pkg.sv ====
package apu_pkg;

    // register map, byte addresses on the APB bus
    localparam logic [7:0] nr10_addr    = 8'h10;
    localparam logic [7:0] nr11_addr    = 8'h11;
    localparam logic [7:0] nr12_addr    = 8'h12;
    localparam logic [7:0] nr13_addr    = 8'h13;
    localparam logic [7:0] nr14_addr    = 8'h14;

    // read-only status window
    localparam logic [7:0] status_addr  = 8'h15;
    localparam logic [7:0] freq_lo_addr = 8'h16;
    localparam logic [7:0] freq_hi_addr = 8'h17;

    // field widths
    localparam int freq_w   = 11;
    localparam int vol_w    = 4;
    localparam int sample_w = 24;

    // NR11 bits 7:6
    typedef enum logic [1:0] {
        duty_12,
        duty_25,
        duty_50,
        duty_75
    } duty_e;

    // NR12 bit 3
    typedef enum logic {
        env_down,
        env_up
    } env_dir_e;

    // NR10 bit 3
    typedef enum logic {
        sweep_add,
        sweep_sub
    } sweep_dir_e;

endpackage : apu_pkg

// ==== source/apu_reg_if.sv ====
`timescale 1ns/1ns

interface apu_reg_if;
    import apu_pkg::*;

    // NR10
    logic [2:0]        sweep_period;
    sweep_dir_e        sweep_dir;
    logic [2:0]        sweep_shift;

    // NR11
    duty_e             duty;
    logic [5:0]        length_load;

    // NR12
    logic [vol_w-1:0]  env_init;
    env_dir_e          env_dir;
    logic [2:0]        env_period;

    // NR13 / NR14
    logic [freq_w-1:0] freq;
    logic              length_en;
    logic              trigger;

    modport regs (
        output sweep_period, sweep_dir, sweep_shift,
        output duty, length_load,
        output env_init, env_dir, env_period,
        output freq, length_en, trigger
    );

    modport unit (
        input sweep_period, sweep_dir, sweep_shift,
        input duty, length_load,
        input env_init, env_dir, env_period,
        input freq, length_en, trigger
    );

endinterface : apu_reg_if

// ==== source/apu_frame_if.sv ====
`timescale 1ns/1ns

interface apu_frame_if;

    // one-cycle pulses from the frame sequencer
    logic length_tick;
    logic sweep_tick;
    logic env_tick;

    // follows the trigger by one cycle
    logic restart;

    modport seq (
        output length_tick,
        output sweep_tick,
        output env_tick,
        output restart
    );

    modport unit (
        input length_tick,
        input sweep_tick,
        input env_tick,
        input restart
    );

endinterface : apu_frame_if

// ==== source/apu_apb_regs.sv ====
`timescale 1ns/1ns

module apu_apb_regs (
    input  logic                       system_clock,
    input  logic                       rst_n,
    input  logic [7:0]                 paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 pwdata,
    output logic [7:0]                 prdata,
    output logic                       pready,
    output logic                       pslverr,
    apu_reg_if.regs                    regs,
    input  logic [apu_pkg::freq_w-1:0] shadow_freq,
    input  logic [apu_pkg::vol_w-1:0]  volume,
    input  logic                       channel_on
);
    import apu_pkg::*;

    logic [7:0] nr10;
    logic [7:0] nr11;
    logic [7:0] nr12;
    logic [7:0] nr13;
    logic [7:0] nr14;
    logic       access;
    logic       addr_ok;
    logic       addr_ro;
    logic       wr_ok;

    assign access  = psel && penable;
    assign addr_ok = (paddr >= nr10_addr) && (paddr <= freq_hi_addr);
    assign addr_ro = (paddr >= status_addr) && (paddr <= freq_hi_addr);
    assign wr_ok   = access && pwrite && addr_ok && !addr_ro;

    // zero wait states
    assign pready  = access;
    assign pslverr = access && (!addr_ok || (pwrite && addr_ro));

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            nr10         <= 8'h00;
            nr11         <= 8'h00;
            nr12         <= 8'h00;
            nr13         <= 8'h00;
            nr14         <= 8'h00;
            regs.trigger <= 1'b0;
        end else begin
            regs.trigger <= wr_ok && (paddr == nr14_addr) && pwdata[7];
            if (wr_ok) begin
                case (paddr)
                    nr10_addr: nr10 <= pwdata;
                    nr11_addr: nr11 <= pwdata;
                    nr12_addr: nr12 <= pwdata;
                    nr13_addr: nr13 <= pwdata;
                    // trigger bit is a strobe, never stored
                    nr14_addr: nr14 <= {1'b0, pwdata[6:0]};
                    default:   ;
                endcase
            end
        end
    end

    always_comb begin
        case (paddr)
            nr10_addr:    prdata = nr10;
            nr11_addr:    prdata = nr11;
            nr12_addr:    prdata = nr12;
            nr13_addr:    prdata = nr13;
            nr14_addr:    prdata = nr14;
            status_addr:  prdata = {channel_on, 3'b000, volume};
            freq_lo_addr: prdata = shadow_freq[7:0];
            freq_hi_addr: prdata = {5'b00000, shadow_freq[freq_w-1:8]};
            default:      prdata = 8'h00;
        endcase
    end

    // field unpacking
    assign regs.sweep_period = nr10[6:4];
    assign regs.sweep_dir    = sweep_dir_e'(nr10[3]);
    assign regs.sweep_shift  = nr10[2:0];
    assign regs.duty         = duty_e'(nr11[7:6]);
    assign regs.length_load  = nr11[5:0];
    assign regs.env_init     = nr12[7:4];
    assign regs.env_dir      = env_dir_e'(nr12[3]);
    assign regs.env_period   = nr12[2:0];
    assign regs.freq         = {nr14[2:0], nr13};
    assign regs.length_en    = nr14[6];

endmodule : apu_apb_regs

// ==== source/apu_frame_sequencer.sv ====
`timescale 1ns/1ns

module apu_frame_sequencer #(
    parameter int FRAME_DIV = 8192
) (
    input  logic      system_clock,
    input  logic      rst_n,
    apu_reg_if.unit   regs,
    apu_frame_if.seq  frame,
    input  logic      overflow,
    output logic      channel_on
);

    localparam int div_w = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

    typedef enum logic {
        ch_off,
        ch_on
    } ch_state_e;

    ch_state_e        state;
    logic [div_w-1:0] div_cnt;
    logic             frame_step;
    logic [2:0]       step;
    logic [6:0]       len_cnt;
    logic             len_dec;

    // 512 Hz equivalent step
    assign frame_step = (div_cnt == div_w'(FRAME_DIV - 1));

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            step    <= 3'd0;
        end else if (frame_step) begin
            div_cnt <= '0;
            step    <= step + 3'd1;
        end else begin
            div_cnt <= div_cnt + div_w'(1);
        end
    end

    // length on even steps, sweep on 2 and 6, envelope on 7
    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            frame.length_tick <= 1'b0;
            frame.sweep_tick  <= 1'b0;
            frame.env_tick    <= 1'b0;
            frame.restart     <= 1'b0;
        end else begin
            frame.length_tick <= frame_step && !step[0];
            frame.sweep_tick  <= frame_step && (step[1:0] == 2'b10);
            frame.env_tick    <= frame_step && (step == 3'd7);
            frame.restart     <= regs.trigger;
        end
    end

    assign len_dec = frame.length_tick && regs.length_en && (len_cnt != 7'd0);

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ch_off;
            len_cnt <= 7'd0;
        end else if (regs.trigger) begin
            state   <= ch_on;
            len_cnt <= 7'd64 - {1'b0, regs.length_load};
        end else begin
            if (len_dec) begin
                len_cnt <= len_cnt - 7'd1;
            end
            // expiry or sweep overflow kills the channel
            if ((len_dec && (len_cnt == 7'd1)) || overflow) begin
                state <= ch_off;
            end
        end
    end

    assign channel_on = (state == ch_on);

endmodule : apu_frame_sequencer

// ==== source/sweep_unit.sv ====
`timescale 1ns/1ns

module sweep_unit (
    input  logic                       system_clock,
    input  logic                       rst_n,
    apu_reg_if.unit                    regs,
    apu_frame_if.unit                  frame,
    output logic [apu_pkg::freq_w-1:0] shadow_freq,
    output logic                       overflow
);
    import apu_pkg::*;

    logic [2:0]        timer;
    logic [freq_w-1:0] delta;
    logic [freq_w:0]   next_freq;
    logic              sweep_now;

    assign delta = shadow_freq >> regs.sweep_shift;

    // msb of the add result flags anything above 2047
    always_comb begin
        if (regs.sweep_dir == sweep_sub) begin
            next_freq = {1'b0, shadow_freq - delta};
        end else begin
            next_freq = {1'b0, shadow_freq} + {1'b0, delta};
        end
    end

    assign sweep_now = frame.sweep_tick && (regs.sweep_period != 3'd0)
                       && (timer <= 3'd1);

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            shadow_freq <= '0;
            timer       <= 3'd0;
            overflow    <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (frame.restart) begin
                shadow_freq <= regs.freq;
                timer       <= regs.sweep_period;
            end else if (frame.sweep_tick && (regs.sweep_period != 3'd0)) begin
                if (sweep_now) begin
                    timer <= regs.sweep_period;
                    if (regs.sweep_shift != 3'd0) begin
                        if (next_freq[freq_w]) begin
                            overflow <= 1'b1;
                        end else begin
                            shadow_freq <= next_freq[freq_w-1:0];
                        end
                    end
                end else begin
                    timer <= timer - 3'd1;
                end
            end
        end
    end

endmodule : sweep_unit

// ==== source/envelope_unit.sv ====
`timescale 1ns/1ns

module envelope_unit (
    input  logic                      system_clock,
    input  logic                      rst_n,
    apu_reg_if.unit                   regs,
    apu_frame_if.unit                 frame,
    output logic [apu_pkg::vol_w-1:0] volume
);
    import apu_pkg::*;

    logic [2:0] timer;
    logic       step_now;
    logic       at_limit;

    assign step_now = frame.env_tick && (regs.env_period != 3'd0) && (timer <= 3'd1);

    // saturate at 15 going up, 0 going down
    assign at_limit = (regs.env_dir == env_up) ? (volume == {vol_w{1'b1}})
                                               : (volume == '0);

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            volume <= '0;
            timer  <= 3'd0;
        end else if (frame.restart) begin
            volume <= regs.env_init;
            timer  <= regs.env_period;
        end else if (frame.env_tick && (regs.env_period != 3'd0)) begin
            if (step_now) begin
                timer <= regs.env_period;
                if (!at_limit) begin
                    if (regs.env_dir == env_up) begin
                        volume <= volume + vol_w'(1);
                    end else begin
                        volume <= volume - vol_w'(1);
                    end
                end
            end else begin
                timer <= timer - 3'd1;
            end
        end
    end

endmodule : envelope_unit

// ==== source/square_duty_gen.sv ====
`timescale 1ns/1ns

module square_duty_gen (
    input  logic                                system_clock,
    input  logic                                rst_n,
    apu_reg_if.unit                             regs,
    input  logic [apu_pkg::freq_w-1:0]          shadow_freq,
    input  logic [apu_pkg::vol_w-1:0]           volume,
    input  logic                                channel_on,
    output logic signed [apu_pkg::sample_w-1:0] output_wave
);
    import apu_pkg::*;

    localparam int timer_w = freq_w + 3;

    logic [freq_w:0]             period;
    logic [timer_w-1:0]          reload;
    logic [timer_w-1:0]          timer;
    logic                        expired;
    logic [2:0]                  pos;
    logic [7:0]                  pattern;
    logic signed [sample_w-1:0]  mag;

    // (2048 - f) * 4 system clocks per eighth step
    assign period  = {1'b1, {freq_w{1'b0}}} - {1'b0, shadow_freq};
    assign reload  = {period, 2'b00};
    assign expired = (timer <= timer_w'(1));

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
            pos   <= 3'd0;
        end else if (regs.trigger) begin
            timer <= reload;
            pos   <= 3'd0;
        end else if (expired) begin
            timer <= reload;
            pos   <= pos + 3'd1;
        end else begin
            timer <= timer - timer_w'(1);
        end
    end

    always_comb begin
        case (regs.duty)
            duty_12: pattern = 8'b0000_0001;
            duty_25: pattern = 8'b0000_0011;
            duty_50: pattern = 8'b0000_1111;
            default: pattern = 8'b0011_1111;
        endcase
    end

    assign mag = sample_w'(volume) << 16;

    always_ff @(posedge system_clock or negedge rst_n) begin
        if (!rst_n) begin
            output_wave <= '0;
        end else if (!channel_on) begin
            output_wave <= '0;
        end else begin
            output_wave <= pattern[pos] ? mag : -mag;
        end
    end

endmodule : square_duty_gen

// ==== source/apu_square1.sv ====
`timescale 1ns/1ns

module apu_square1 #(
    parameter int FRAME_DIV = 8192
) (
    input  logic                                system_clock,
    input  logic                                rst_n,
    input  logic [7:0]                          paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [7:0]                          pwdata,
    output logic [7:0]                          prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic signed [apu_pkg::sample_w-1:0] output_wave
);
    import apu_pkg::*;

    logic [freq_w-1:0] shadow_freq;
    logic [vol_w-1:0]  volume;
    logic              overflow;
    logic              channel_on;

    apu_reg_if   reg_bus ();
    apu_frame_if frame_bus ();

    apu_apb_regs u_regs (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .regs(reg_bus.regs),
        .shadow_freq(shadow_freq),
        .volume(volume),
        .channel_on(channel_on)
    );

    apu_frame_sequencer #(.FRAME_DIV(FRAME_DIV)) u_seq (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .regs(reg_bus.unit),
        .frame(frame_bus.seq),
        .overflow(overflow),
        .channel_on(channel_on)
    );

    sweep_unit u_sweep (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .regs(reg_bus.unit),
        .frame(frame_bus.unit),
        .shadow_freq(shadow_freq),
        .overflow(overflow)
    );

    envelope_unit u_env (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .regs(reg_bus.unit),
        .frame(frame_bus.unit),
        .volume(volume)
    );

    square_duty_gen u_duty (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .regs(reg_bus.unit),
        .shadow_freq(shadow_freq),
        .volume(volume),
        .channel_on(channel_on),
        .output_wave(output_wave)
    );

endmodule : apu_square1

// ==== sim/tb_apu_square1.sv ====
`timescale 1ns/1ns

module tb_apu_square1;
    import apu_pkg::*;

    localparam int FRAME_DIV = 16;

    logic                       system_clock = 1'b0;
    logic                       rst_n;
    logic [7:0]                 paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [7:0]                 pwdata;
    logic [7:0]                 prdata;
    logic                       pready;
    logic                       pslverr;
    logic signed [sample_w-1:0] output_wave;

    string       vec_name[$];
    string       vec_op[$];
    logic [31:0] vec_addr[$];
    logic [31:0] vec_data[$];
    logic [31:0] vec_exp[$];
    logic [31:0] vec_err[$];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int seed = 96;

    apu_square1 #(.FRAME_DIV(FRAME_DIV)) u_apu_square1 (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .output_wave(output_wave)
    );

    always #20 system_clock = ~system_clock;

    always @(posedge system_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          wait_sum;
        int          access_count;
        string       line;
        string       nm;
        string       op;
        logic [31:0] a, d, e, r;
        wait_sum = 0;
        access_count = 0;
        fd = $fopen("sim/apu_square1_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/apu_square1_vectors.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h", nm, op, a, d, e, r);
                    if (n == 6) begin
                        vec_name.push_back(nm);
                        vec_op.push_back(op);
                        vec_addr.push_back(a);
                        vec_data.push_back(d);
                        vec_exp.push_back(e);
                        vec_err.push_back(r);
                        if (op == "wait" || op == "sample") begin
                            wait_sum += int'(d);
                        end else begin
                            access_count++;
                        end
                    end else begin
                        $display("vector line could not be parsed: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
        // reset cycles on top
        cycle_limit = 2 * wait_sum + 20 * access_count + 3;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge system_clock);
            #2;
        end
    endtask

    task automatic apb_write(input string name, input logic [7:0] addr, input logic [7:0] data,
                             output logic err);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        // zero wait states, pready only in the access phase
        @(negedge system_clock);
        check_value({name, " pready setup"}, 32'd0, {31'b0, pready});
        @(posedge system_clock);
        #2;
        penable = 1'b1;
        @(negedge system_clock);
        err = pslverr;
        check_value({name, " pready"}, 32'd1, {31'b0, pready});
        @(posedge system_clock);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input string name, input logic [7:0] addr, output logic [7:0] data,
                            output logic err);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge system_clock);
        check_value({name, " pready setup"}, 32'd0, {31'b0, pready});
        @(posedge system_clock);
        #2;
        penable = 1'b1;
        // mid access phase
        @(negedge system_clock);
        data = prdata;
        err = pslverr;
        check_value({name, " pready"}, 32'd1, {31'b0, pready});
        @(posedge system_clock);
        #2;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // every sample is +/- vol * 65536, positives counted over the window
    task automatic sample_wave(input string name, input logic [31:0] vol, input int cycles,
                               input logic [31:0] expected_high);
        int wv;
        int mag;
        int high;
        high = 0;
        repeat (cycles) begin
            @(posedge system_clock);
            #2;
            wv = int'(output_wave);
            mag = (wv < 0) ? -wv : wv;
            check_value(name, vol * 65536, mag);
            if (wv > 0) begin
                high++;
            end
        end
        check_value({name, " high count"}, expected_high, high);
    endtask

    initial begin
        logic [7:0] rd;
        logic       err;
        int         gap;
        rst_n = 1'b0;
        paddr = 8'h00;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 8'h00;
        load_vectors();
        repeat (3) @(posedge system_clock);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < vec_op.size(); i++) begin
            if (vec_op[i] == "write") begin
                // reads keep an exact distance from the preceding wait
                gap = $unsigned($random(seed)) % 4;
                idle_cycles(gap);
                apb_write(vec_name[i], vec_addr[i][7:0], vec_data[i][7:0], err);
                check_value({vec_name[i], " pslverr"}, vec_err[i], {31'b0, err});
            end else if (vec_op[i] == "read") begin
                apb_read(vec_name[i], vec_addr[i][7:0], rd, err);
                check_value(vec_name[i], vec_exp[i], {24'b0, rd});
                check_value({vec_name[i], " pslverr"}, vec_err[i], {31'b0, err});
            end else if (vec_op[i] == "wait") begin
                idle_cycles(int'(vec_data[i]));
            end else if (vec_op[i] == "sample") begin
                sample_wave(vec_name[i], vec_addr[i], int'(vec_data[i]), vec_exp[i]);
            end else begin
                $display("unknown operation %s in test %s", vec_op[i], vec_name[i]);
                error_count++;
            end
        end
        $display("run complete: %0d vectors, %0d errors", vec_op.size(), error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_apu_square1

// ==== sim/apu_square1_vectors.txt ====
# name op addr data expected pslverr, numbers in hex
# wait and sample take a cycle count in data; sample takes the volume in addr, positives in expected
reg_rw write 10 5a 00 0
reg_rw write 11 9b 00 0
reg_rw write 12 c3 00 0
reg_rw write 13 e7 00 0
reg_rw write 14 c5 00 0
reg_rw read 10 00 5a 0
reg_rw read 11 00 9b 0
reg_rw read 12 00 c3 0
reg_rw read 13 00 e7 0
nr14_trig read 14 00 45 0
bad_addr read 20 00 00 1
bad_addr write 20 11 00 1
ro_write write 15 ff 00 1
ro_write read 13 00 e7 0
# length 64 - 60 = 4 ticks, one per 32 cycles
len_on write 10 00 00 0
len_on write 11 3c 00 0
len_on write 12 a0 00 0
len_on write 13 00 00 0
len_on write 14 c7 00 0
len_on wait 00 40 00 0
len_on read 15 00 8a 0
len_off wait 00 7e 00 0
len_off read 15 00 0a 0
len_hold write 14 87 00 0
len_hold wait 00 c0 00 0
len_hold read 15 00 8a 0
# envelope steps every 128 cycles
env_up write 11 00 00 0
env_up write 12 29 00 0
env_up write 14 80 00 0
env_up wait 00 01 00 0
env_up read 15 00 82 0
env_up wait 00 17e 00 0
env_up read 15 00 85 0
env_down write 12 11 00 0
env_down write 14 80 00 0
env_down wait 00 01 00 0
env_down read 15 00 81 0
env_down wait 00 100 00 0
env_down read 15 00 80 0
env_down wait 00 100 00 0
env_down read 15 00 80 0
# sweep steps every 64 cycles
sw_add write 10 11 00 0
sw_add write 12 f0 00 0
sw_add write 13 00 00 0
sw_add write 14 84 00 0
sw_add wait 00 01 00 0
sw_add read 15 00 8f 0
sw_add wait 00 64 00 0
sw_add read 16 00 00 0
sw_add read 17 00 06 0
sw_ovf wait 00 80 00 0
sw_ovf read 15 00 0f 0
sw_ovf read 17 00 06 0
sw_sub write 10 19 00 0
sw_sub write 14 84 00 0
sw_sub wait 00 41 00 0
sw_sub read 17 00 02 0
sw_sub wait 00 3e 00 0
sw_sub read 17 00 01 0
sw_sub read 16 00 00 0
# freq 0x7fc gives 16 cycles per eighth step, 128 per duty period
wave_50 write 10 00 00 0
wave_50 write 11 80 00 0
wave_50 write 12 70 00 0
wave_50 write 13 fc 00 0
wave_50 write 14 87 00 0
wave_50 wait 00 02 00 0
wave_50 write 14 87 00 0
wave_50 wait 00 04 00 0
wave_50 sample 07 80 40 0
wave_12 write 11 00 00 0
wave_12 sample 07 80 10 0
wave_25 write 11 40 00 0
wave_25 sample 07 80 20 0
wave_75 write 11 c0 00 0
wave_75 sample 07 80 60 0
wave_off write 11 3f 00 0
wave_off write 14 c7 00 0
wave_off wait 00 40 00 0
wave_off sample 00 10 00 0
wave_off read 15 00 07 0

// ==== tb.f ====
source/apu_pkg.sv
source/apu_reg_if.sv
source/apu_frame_if.sv
source/apu_apb_regs.sv
source/apu_frame_sequencer.sv
source/sweep_unit.sv
source/envelope_unit.sv
source/square_duty_gen.sv
source/apu_square1.sv
sim/tb_apu_square1.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_apu_square1

verilator --binary --timing --top-module "$TOP" -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
